// File: verilog.f
rtl/fetch_pkg.sv
rtl/fetch_wr_if.sv
rtl/fetch_fifo.sv
rtl/if_stage.sv
rtl/fetch_top.sv
dv/icache_model.sv
dv/tb_fetch_top.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --timing --timescale 1ns/1ps
TOP      := tb_fetch_top
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log

SOURCES  := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/tb_fetch_top.sv
// fetch subsystem testbench
// plays PC generator and decode, checks every entry against the address rules

module tb_fetch_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CycleLimit = 4000;
    localparam int PopTarget  = 400;
    // starts just below the fault region so the run crosses into it
    localparam logic [fetch_pkg::XLEN-1:0] StartPc = 64'h0000_0000_7fff_ff80;

    logic                       clk_i;
    logic                       rst_ni;
    logic                       flush_i;
    logic                       if_busy_o;
    logic [fetch_pkg::XLEN-1:0] fetch_address_i;
    logic                       fetch_valid_i;
    fetch_pkg::branchpredict_t  branch_predict_i;
    logic                       instr_req_o;
    logic [fetch_pkg::XLEN-1:0] instr_addr_o;
    logic                       instr_gnt_i;
    logic                       instr_rvalid_i;
    logic [fetch_pkg::ILEN-1:0] instr_rdata_i;
    fetch_pkg::exception_t      instr_ex_i;
    fetch_pkg::fetch_entry_t    fetch_entry_0_o;
    fetch_pkg::fetch_entry_t    fetch_entry_1_o;
    logic                       fetch_entry_valid_0_o;
    logic                       fetch_entry_valid_1_o;
    logic                       fetch_ack_0_i;
    logic                       fetch_ack_1_i;

    int unsigned                seed_val;
    int                         errors;
    int                         cache_errors;
    int                         cycles;
    int                         pops;
    logic                       running;
    logic                       timed_out;
    logic                       fire;
    logic                       was_flush;
    logic                       hold_req;
    logic                       after_flush;
    logic [fetch_pkg::XLEN-1:0] pc;
    logic [fetch_pkg::XLEN-1:0] flush_target;
    logic [fetch_pkg::XLEN-1:0] exp_addr;
    logic [fetch_pkg::XLEN-1:0] held_addr;

    fetch_top #(
        .FifoDepth (4)
    ) fetch_top_i (
        .clk_i, .rst_ni, .flush_i, .if_busy_o, .fetch_address_i, .fetch_valid_i,
        .branch_predict_i, .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i,
        .instr_rdata_i, .instr_ex_i, .fetch_entry_0_o, .fetch_entry_valid_0_o, .fetch_ack_0_i,
        .fetch_entry_1_o, .fetch_entry_valid_1_o, .fetch_ack_1_i
    );

    icache_model icache_i (
        .clk_i (clk_i), .rst_ni (rst_ni), .req_i (instr_req_o), .addr_i (instr_addr_o),
        .gnt_o (instr_gnt_i), .rvalid_o (instr_rvalid_i), .rdata_o (instr_rdata_i),
        .ex_o (instr_ex_i), .error_count_o (cache_errors)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------
    // reference model
    // ------------------------------
    // prediction rule shared by the PC generator and the expected entries
    function automatic fetch_pkg::branchpredict_t prediction_of(
        input logic [fetch_pkg::XLEN-1:0] addr);
        fetch_pkg::branchpredict_t bp;
        bp.taken     = addr[3];
        bp.target    = addr + 64'h40;
        bp.is_branch = addr[3];
        return bp;
    endfunction

    function automatic fetch_pkg::fetch_entry_t expected_entry(
        input logic [fetch_pkg::XLEN-1:0] addr);
        fetch_pkg::fetch_entry_t e;
        logic                    fault;
        fault         = (addr >= 64'h8000_0000);
        e.address     = addr;
        e.instruction = (addr[31:0] >> 2) ^ 32'h1357_9bdf;
        e.bp          = prediction_of(addr);
        e.ex.valid    = fault;
        e.ex.cause    = fault ? fetch_pkg::CAUSE_ACCESS_FAULT : fetch_pkg::CAUSE_NONE;
        e.ex.tval     = fault ? addr : '0;
        return e;
    endfunction

    task automatic compare_addr(input string sig, input logic [fetch_pkg::XLEN-1:0] got,
                                input logic [fetch_pkg::XLEN-1:0] exp);
        if (got != exp) begin
            errors++;
            $display("[FAIL] %s: got %h expected %h", sig, got, exp);
        end
    endtask

    // payload of one entry against the rules for its own address
    task automatic verify_entry(input string sig, input fetch_pkg::fetch_entry_t got);
        fetch_pkg::fetch_entry_t exp;
        exp = expected_entry(got.address);
        if (got.instruction != exp.instruction) begin
            errors++;
            $display("[FAIL] %s.instruction: got %h expected %h", sig, got.instruction,
                     exp.instruction);
        end
        if (got.bp != exp.bp) begin
            errors++;
            $display("[FAIL] %s.bp: got %h expected %h", sig, got.bp, exp.bp);
        end
        if (got.ex != exp.ex) begin
            errors++;
            $display("[FAIL] %s.ex: got %h expected %h", sig, got.ex, exp.ex);
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic drive_pc_gen(input logic last_was_flush);
        logic [31:0] jump;
        jump          = $urandom();
        flush_i       = 1'b0;
        fetch_valid_i = ($urandom_range(99) < 70);
        // rare flush, jumps to a random word anywhere in the low 4 GiB
        if (!last_was_flush && $urandom_range(199) < 3) begin
            flush_i       = 1'b1;
            fetch_valid_i = 1'b0;
            flush_target  = {32'h0, jump[31:2], 2'b00};
        end
        // random low bits, the DUT must align them away
        fetch_address_i  = {pc[fetch_pkg::XLEN-1:2], 2'($urandom_range(3))};
        branch_predict_i = prediction_of(pc);
    endtask

    // none, one, two, or ack_1 alone which has to be ignored
    task automatic drive_decode_acks();
        int unsigned pick;
        pick          = $urandom_range(3);
        fetch_ack_0_i = 1'b0;
        fetch_ack_1_i = 1'b0;
        // stall windows let the FIFO run into back-pressure
        if (!flush_i && (cycles % 300) >= 40) begin
            fetch_ack_0_i = (pick == 1) || (pick == 2);
            fetch_ack_1_i = (pick == 2) || (pick == 3);
        end
    endtask

    initial begin
        wait (running);
        forever begin
            @(negedge clk_i);
            fire      = instr_req_o && instr_gnt_i;
            was_flush = flush_i;
            @(posedge clk_i);
            #1;
            if (was_flush) begin
                pc = flush_target;
            end else if (fire) begin
                pc = pc + 64'd4;
            end
            drive_pc_gen(was_flush);
            drive_decode_acks();
        end
    end

    // ------------------------------
    // checks, mid cycle
    // ------------------------------
    always @(negedge clk_i) begin
        if (running) begin
            if (hold_req && !instr_req_o) begin
                errors++;
                $display("request withdrawn before it was granted");
            end
            if (instr_req_o) begin
                if (hold_req) begin
                    compare_addr("instr_addr_o (held)", instr_addr_o, held_addr);
                end
                compare_addr("instr_addr_o", instr_addr_o, pc);
            end
            hold_req  = instr_req_o && !instr_gnt_i && !flush_i;
            held_addr = instr_addr_o;
            // FIFO must be empty the cycle after a flush
            if (after_flush && fetch_entry_valid_0_o) begin
                errors++;
                $display("entry valid in the cycle after a flush");
            end
            after_flush = flush_i;
            if (fetch_entry_valid_0_o) begin
                verify_entry("fetch_entry_0_o", fetch_entry_0_o);
            end
            if (fetch_entry_valid_1_o) begin
                verify_entry("fetch_entry_1_o", fetch_entry_1_o);
                compare_addr("fetch_entry_1_o.address", fetch_entry_1_o.address,
                             fetch_entry_0_o.address + 64'd4);
            end
            // pops in a flush cycle do not count
            if (flush_i) begin
                exp_addr = flush_target;
            end else if (fetch_ack_0_i && fetch_entry_valid_0_o) begin
                compare_addr("fetch_entry_0_o.address", fetch_entry_0_o.address, exp_addr);
                exp_addr = exp_addr + 64'd4;
                pops++;
                if (fetch_ack_1_i && fetch_entry_valid_1_o) begin
                    compare_addr("fetch_entry_1_o.address", fetch_entry_1_o.address, exp_addr);
                    exp_addr = exp_addr + 64'd4;
                    pops++;
                end
            end
        end
    end

    initial begin
        seed_val         = $urandom(9);
        errors           = 0;
        cycles           = 0;
        pops             = 0;
        running          = 1'b0;
        timed_out        = 1'b0;
        hold_req         = 1'b0;
        after_flush      = 1'b0;
        pc               = StartPc;
        exp_addr         = StartPc;
        flush_target     = StartPc;
        held_addr        = '0;
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        fetch_valid_i    = 1'b0;
        fetch_address_i  = StartPc;
        branch_predict_i = prediction_of(StartPc);
        fetch_ack_0_i    = 1'b0;
        fetch_ack_1_i    = 1'b0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // quiet outputs until the first fetch_valid_i
        repeat (6) begin
            @(negedge clk_i);
            if (instr_req_o || fetch_entry_valid_0_o || fetch_entry_valid_1_o || if_busy_o) begin
                errors++;
                $display("outputs active after reset before any fetch request");
            end
        end
        running = 1'b1;
        while (pops < PopTarget && cycles < CycleLimit) begin
            @(posedge clk_i);
            cycles++;
        end
        timed_out = (pops < PopTarget);
        if (timed_out) begin
            $display("timeout: only %0d of %0d entries popped in %0d cycles", pops, PopTarget,
                     cycles);
        end
        $display("cycles %0d, popped %0d, check errors %0d, cache model errors %0d, timeout %0d",
                 cycles, pops, errors, cache_errors, timed_out);
        if (errors == 0 && cache_errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: dv/icache_model.sv
// I-cache stand-in for the fetch testbench
// random grants, one response 1 to 3 cycles after each grant, data follows the address

module icache_model (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       req_i,
    input  logic [fetch_pkg::XLEN-1:0] addr_i,
    output logic                       gnt_o,
    output logic                       rvalid_o,
    output logic [fetch_pkg::ILEN-1:0] rdata_o,
    output fetch_pkg::exception_t      ex_o,
    output int                         error_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic                       gnt_roll;
    logic                       pending;
    logic [fetch_pkg::XLEN-1:0] pend_addr;
    int unsigned                delay;

    // a grant can only ever follow a live request
    assign gnt_o = req_i && gnt_roll;

    initial begin
        gnt_roll      = 1'b0;
        rvalid_o      = 1'b0;
        rdata_o       = '0;
        ex_o          = '0;
        error_count_o = 0;
        pending       = 1'b0;
        pend_addr     = '0;
        delay         = 0;
        forever begin
            // sample mid cycle, inputs are settled here
            @(negedge clk_i);
            if (rst_ni && req_i && gnt_o) begin
                if (pending) begin
                    error_count_o++;
                    $display("request granted while a response was still outstanding");
                end
                pending   = 1'b1;
                pend_addr = addr_i;
                delay     = $urandom_range(3, 1);
            end
            @(posedge clk_i);
            #1;
            rvalid_o = 1'b0;
            rdata_o  = '0;
            ex_o     = '0;
            if (pending) begin
                delay--;
                if (delay == 0) begin
                    pending   = 1'b0;
                    rvalid_o  = 1'b1;
                    rdata_o   = (pend_addr[31:0] >> 2) ^ 32'h1357_9bdf;
                    // everything from 0x8000_0000 up is unmapped
                    if (pend_addr >= 64'h8000_0000) begin
                        ex_o.valid = 1'b1;
                        ex_o.cause = fetch_pkg::CAUSE_ACCESS_FAULT;
                        ex_o.tval  = pend_addr;
                    end
                end
            end
            // 60 percent grant chance for the coming cycle
            gnt_roll = rst_ni && ($urandom_range(99) < 60);
        end
    end

endmodule

// File: rtl/fetch_top.sv
// fetch subsystem top level
// flat ports towards PC generator, I-cache and decode, FIFO depth is chosen here

module fetch_top #(
    parameter int unsigned FifoDepth = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    output logic                             if_busy_o,
    input  logic [fetch_pkg::XLEN-1:0]       fetch_address_i,
    input  logic                             fetch_valid_i,
    input  fetch_pkg::branchpredict_t        branch_predict_i,
    output logic                             instr_req_o,
    output logic [fetch_pkg::XLEN-1:0]       instr_addr_o,
    input  logic                             instr_gnt_i,
    input  logic                             instr_rvalid_i,
    input  logic [fetch_pkg::ILEN-1:0]       instr_rdata_i,
    input  fetch_pkg::exception_t            instr_ex_i,
    output fetch_pkg::fetch_entry_t          fetch_entry_0_o,
    output logic                             fetch_entry_valid_0_o,
    input  logic                             fetch_ack_0_i,
    output fetch_pkg::fetch_entry_t          fetch_entry_1_o,
    output logic                             fetch_entry_valid_1_o,
    input  logic                             fetch_ack_1_i
);

    // depth must be a power of two, at least 2
    if_stage #(
        .FifoDepth (FifoDepth)
    ) if_stage_i (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .if_busy_o             (if_busy_o),
        .fetch_address_i       (fetch_address_i),
        .fetch_valid_i         (fetch_valid_i),
        .branch_predict_i      (branch_predict_i),
        .instr_req_o           (instr_req_o),
        .instr_addr_o          (instr_addr_o),
        .instr_gnt_i           (instr_gnt_i),
        .instr_rvalid_i        (instr_rvalid_i),
        .instr_rdata_i         (instr_rdata_i),
        .instr_ex_i            (instr_ex_i),
        .fetch_entry_0_o       (fetch_entry_0_o),
        .fetch_entry_valid_0_o (fetch_entry_valid_0_o),
        .fetch_ack_0_i         (fetch_ack_0_i),
        .fetch_entry_1_o       (fetch_entry_1_o),
        .fetch_entry_valid_1_o (fetch_entry_valid_1_o),
        .fetch_ack_1_i         (fetch_ack_1_i)
    );

endmodule

// File: rtl/if_stage.sv
// instruction fetch stage
// requests words from the I-cache, one response in flight, results go into the fetch FIFO

module if_stage #(
    parameter int unsigned FifoDepth = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    output logic                             if_busy_o,
    // from the PC generator
    input  logic [fetch_pkg::XLEN-1:0]       fetch_address_i,
    input  logic                             fetch_valid_i,
    input  fetch_pkg::branchpredict_t        branch_predict_i,
    // I-cache port
    output logic                             instr_req_o,
    output logic [fetch_pkg::XLEN-1:0]       instr_addr_o,
    input  logic                             instr_gnt_i,
    input  logic                             instr_rvalid_i,
    input  logic [fetch_pkg::ILEN-1:0]       instr_rdata_i,
    input  fetch_pkg::exception_t            instr_ex_i,
    // to decode
    output fetch_pkg::fetch_entry_t          fetch_entry_0_o,
    output logic                             fetch_entry_valid_0_o,
    input  logic                             fetch_ack_0_i,
    output fetch_pkg::fetch_entry_t          fetch_entry_1_o,
    output logic                             fetch_entry_valid_1_o,
    input  logic                             fetch_ack_1_i
);

    fetch_pkg::fetch_state_e      state_q;
    fetch_pkg::fetch_state_e      state_d;
    fetch_pkg::fetch_state_e      req_state;
    fetch_pkg::branchpredict_t    bp_q;

    logic [fetch_pkg::XLEN-1:0]   fetch_address;
    logic [fetch_pkg::XLEN-1:0]   instr_addr_q;
    logic                         addr_valid;
    logic                         fifo_valid;

    fetch_wr_if wr_if ();

    // word aligned, compressed fetch is not supported
    assign fetch_address = {fetch_address_i[fetch_pkg::XLEN-1:2], 2'b00};

    // busy while a request hangs or no room for another one
    assign if_busy_o = (state_q == fetch_pkg::FETCH_WAIT_GNT) || !wr_if.ready;

    // ------------------------------
    // write channel into the FIFO
    // ------------------------------
    assign wr_if.valid = fifo_valid;
    assign wr_if.addr  = instr_addr_q;
    assign wr_if.rdata = instr_rdata_i;
    assign wr_if.ex    = instr_ex_i;
    assign wr_if.bp    = bp_q;

    fetch_fifo #(
        .FifoDepth (FifoDepth)
    ) fetch_fifo_i (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .wr_if                 (wr_if),
        .fetch_entry_0_o       (fetch_entry_0_o),
        .fetch_entry_valid_0_o (fetch_entry_valid_0_o),
        .fetch_ack_0_i         (fetch_ack_0_i),
        .fetch_entry_1_o       (fetch_entry_1_o),
        .fetch_entry_valid_1_o (fetch_entry_valid_1_o),
        .fetch_ack_1_i         (fetch_ack_1_i)
    );

    // ------------------------------
    // fetch FSM
    // ------------------------------
    // where to go once a request is on the bus this cycle
    always_comb begin
        if (instr_gnt_i) begin
            // granted under a flush, its response must be thrown away
            req_state = flush_i ? fetch_pkg::FETCH_WAIT_ABORTED : fetch_pkg::FETCH_WAIT_RVALID;
        end else begin
            // ungranted request is simply dropped on flush
            req_state = flush_i ? fetch_pkg::FETCH_IDLE : fetch_pkg::FETCH_WAIT_GNT;
        end
    end

    always_comb begin
        instr_req_o  = 1'b0;
        instr_addr_o = fetch_address;
        addr_valid   = 1'b0;
        fifo_valid   = 1'b0;
        state_d      = state_q;

        case (state_q)
            fetch_pkg::FETCH_IDLE: begin
                if (fetch_valid_i && wr_if.ready) begin
                    instr_req_o = 1'b1;
                    addr_valid  = 1'b1;
                    state_d     = req_state;
                end
            end
            fetch_pkg::FETCH_WAIT_GNT: begin
                // address must not move until granted
                instr_req_o  = 1'b1;
                instr_addr_o = instr_addr_q;
                state_d      = req_state;
            end
            fetch_pkg::FETCH_WAIT_RVALID: begin
                if (instr_rvalid_i) begin
                    // keep the word unless flushed in the same cycle
                    fifo_valid = !flush_i;
                    state_d    = fetch_pkg::FETCH_IDLE;
                    // back to back request, response slot frees up now
                    if (fetch_valid_i && wr_if.ready) begin
                        instr_req_o = 1'b1;
                        addr_valid  = 1'b1;
                        state_d     = req_state;
                    end
                end else if (flush_i) begin
                    state_d = fetch_pkg::FETCH_WAIT_ABORTED;
                end
            end
            fetch_pkg::FETCH_WAIT_ABORTED: begin
                // no new request before the stale response is gone
                if (instr_rvalid_i) begin
                    state_d = fetch_pkg::FETCH_IDLE;
                    if (fetch_valid_i && wr_if.ready) begin
                        instr_req_o = 1'b1;
                        addr_valid  = 1'b1;
                        state_d     = req_state;
                    end
                end
            end
            default: begin
                state_d = fetch_pkg::FETCH_IDLE;
            end
        endcase
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= fetch_pkg::FETCH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address and prediction of the request that went out
    always_ff @(posedge clk_i) begin
        if (addr_valid) begin
            instr_addr_q <= fetch_address;
            bp_q         <= branch_predict_i;
        end
    end

endmodule

// File: rtl/fetch_fifo.sv
// dual read window fetch FIFO
// circular buffer of fetch entries, one write and up to two pops per cycle

module fetch_fifo #(
    parameter int unsigned FifoDepth = 4
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    // write from the fetch control
    fetch_wr_if.write               wr_if,
    // decode window
    output fetch_pkg::fetch_entry_t fetch_entry_0_o,
    output logic                    fetch_entry_valid_0_o,
    input  logic                    fetch_ack_0_i,
    output fetch_pkg::fetch_entry_t fetch_entry_1_o,
    output logic                    fetch_entry_valid_1_o,
    input  logic                    fetch_ack_1_i
);

    localparam int unsigned PtrW = $clog2(FifoDepth);
    localparam int unsigned CntW = PtrW + 1;
    // highest fill level that still leaves two slots free
    localparam logic [CntW-1:0] ReadyMax = CntW'(FifoDepth - 2);
    localparam logic [CntW-1:0] CntOne   = CntW'(1);
    localparam logic [CntW-1:0] CntTwo   = CntW'(2);

    fetch_pkg::fetch_entry_t mem_q [FifoDepth];
    fetch_pkg::fetch_entry_t wr_entry;

    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW-1:0] rd_ptr_1;
    logic [PtrW-1:0] wr_ptr_q;
    logic [CntW-1:0] cnt_q;
    logic [CntW-1:0] pop_cnt;
    logic [CntW-1:0] push_cnt;
    logic            push;

    // ------------------------------
    // status and read windows
    // ------------------------------
    assign wr_if.ready           = (cnt_q <= ReadyMax);
    assign fetch_entry_valid_0_o = (cnt_q != '0);
    assign fetch_entry_valid_1_o = (cnt_q >= CntTwo);

    // second window wraps for free, depth is a power of two
    assign rd_ptr_1        = rd_ptr_q + PtrW'(1);
    assign fetch_entry_0_o = mem_q[rd_ptr_q];
    assign fetch_entry_1_o = mem_q[rd_ptr_1];

    // ack_1 alone does nothing, ack_1 only counts on top of ack_0
    always_comb begin
        pop_cnt = '0;
        if (fetch_ack_0_i && fetch_entry_valid_0_o) begin
            pop_cnt = CntOne;
            if (fetch_ack_1_i && fetch_entry_valid_1_o) begin
                pop_cnt = CntTwo;
            end
        end
    end

    // a write that coincides with a flush belongs to the old stream
    assign push     = wr_if.valid && !flush_i;
    assign push_cnt = push ? CntOne : '0;

    // ------------------------------
    // entry assembly
    // ------------------------------
    always_comb begin
        wr_entry.address     = wr_if.addr;
        wr_entry.instruction = wr_if.rdata;
        wr_entry.bp          = wr_if.bp;
        wr_entry.ex          = wr_if.ex;
    end

    // storage, payload only
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_entry;
        end
    end

    // ------------------------------
    // pointers and fill level
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // drop everything, pops in this cycle are moot
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            // pop of two wraps correctly even for a depth of two
            rd_ptr_q <= rd_ptr_q + pop_cnt[PtrW-1:0];
            if (push) begin
                wr_ptr_q <= wr_ptr_q + PtrW'(1);
            end
            cnt_q <= cnt_q + push_cnt - pop_cnt;
        end
    end

endmodule

// File: rtl/fetch_wr_if.sv
// fetch write channel
// one returned instruction with its address, prediction and exception into the FIFO

interface fetch_wr_if;

    // write strobe, high for exactly the cycles that store an entry
    logic                              valid;
    // address of the pending request
    logic [fetch_pkg::XLEN-1:0]        addr;
    logic [fetch_pkg::ILEN-1:0]        rdata;
    fetch_pkg::exception_t             ex;
    fetch_pkg::branchpredict_t         bp;
    // at least two free slots, one kept for the response in flight
    logic                              ready;

    // fetch control side
    modport fetch (output valid, addr, rdata, ex, bp, input ready);

    // FIFO side, takes the write
    modport write (input valid, addr, rdata, ex, bp, output ready);

endinterface

// File: rtl/fetch_pkg.sv
// fetch subsystem package
// address and instruction widths plus the types that travel from fetch to decode

package fetch_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int unsigned XLEN = 64;
    localparam int unsigned ILEN = 32;

    // ------------------------------
    // exceptions
    // ------------------------------
    // fetch side causes only, 2 bits
    typedef enum logic [1:0] {
        CAUSE_NONE         = 2'd0,
        CAUSE_ACCESS_FAULT = 2'd1,
        CAUSE_PAGE_FAULT   = 2'd2
    } fetch_cause_e;

    typedef struct packed {
        logic              valid;
        fetch_cause_e      cause;
        // faulting address
        logic [XLEN-1:0]   tval;
    } exception_t;

    // prediction handed over by the PC generator
    typedef struct packed {
        logic              taken;
        logic [XLEN-1:0]   target;
        logic              is_branch;
    } branchpredict_t;

    // one slot of the fetch FIFO, as seen by decode
    typedef struct packed {
        logic [XLEN-1:0]   address;
        logic [ILEN-1:0]   instruction;
        branchpredict_t    bp;
        exception_t        ex;
    } fetch_entry_t;

    // fetch control FSM, only if_stage uses it
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT_GNT,
        FETCH_WAIT_RVALID,
        FETCH_WAIT_ABORTED
    } fetch_state_e;

endpackage
